// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes, bits [6:0] of the instruction word
  // only the classes this core executes are listed
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    auipc  = 7'b0010111,
    lui    = 7'b0110111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    system = 7'b1110011
  } rv_opcode_e;

  // funct3 for addi inside op_imm
  localparam logic [2:0] funct3_addi = 3'b000;

  // funct3 shared by ecall and ebreak inside system
  localparam logic [2:0] funct3_priv = 3'b000;

  // imm field of ebreak, tells it apart from ecall
  localparam logic [11:0] imm_ebreak = 12'h001;

  // immediate layouts
  // fmt_i covers addi, jalr and the system word
  // fmt_u covers lui and auipc
  // fmt_j covers jal
  typedef enum logic [1:0] {
    fmt_i,
    fmt_u,
    fmt_j,
    fmt_none
  } imm_fmt_e;

endpackage

// ==== rtl/core_pkg.sv ====
package core_pkg;

  // register and datapath width
  localparam int xlen = 64;

  // execute operation byte
  // only add is used so far
  typedef enum logic [7:0] {
    alu_none = 8'h00,
    alu_add  = 8'h01
  } alu_op_e;

  // why the core stopped
  // halt_none while it is still running
  typedef enum logic [1:0] {
    halt_none,
    halt_ebreak,
    halt_illegal,
    halt_fetch_err
  } halt_cause_e;

endpackage

// ==== rtl/ifu.sv ====
module ifu #(
  parameter logic [31:0] reset_pc = 32'h8000_0000
) (
  input  logic                     clk,
  input  logic                     reset,
  // axi4-lite read address channel
  output logic [31:0]              araddr,
  output logic [2:0]               arprot,
  output logic                     arvalid,
  input  logic                     arready,
  // axi4-lite read data channel
  input  logic [31:0]              rdata,
  input  logic [1:0]               rresp,
  input  logic                     rvalid,
  output logic                     rready,
  // decoder flags for the word in execute
  input  logic                     inst_ebreak,
  input  logic                     invalid_inst,
  input  logic [31:0]              next_pc,
  output logic [31:0]              inst,
  output logic [31:0]              pc,
  output logic                     exec_valid,
  output logic                     halted,
  output core_pkg::halt_cause_e    halt_cause
);

  typedef enum logic [1:0] {
    fetch_addr,
    fetch_data,
    execute,
    stop
  } state_e;

  state_e state;

  // request address is the pc, stable while arvalid waits
  assign araddr = pc;
  // data access, unprivileged, secure
  assign arprot = 3'b000;

  // one instruction in flight, execute lasts a single cycle
  assign exec_valid = (state == execute);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= fetch_addr;
      pc         <= reset_pc;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      halted     <= 1'b0;
      halt_cause <= core_pkg::halt_none;
    end else begin
      case (state)
        fetch_addr: begin
          // raise the request, drop it once accepted
          arvalid <= 1'b1;
          if (arvalid && arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= fetch_data;
          end
        end
        fetch_data: begin
          if (rvalid) begin
            rready <= 1'b0;
            if (rresp != 2'b00) begin
              // bad fetch, word is dropped without commit
              state      <= stop;
              halted     <= 1'b1;
              halt_cause <= core_pkg::halt_fetch_err;
            end else begin
              state <= execute;
            end
          end
        end
        execute: begin
          if (inst_ebreak) begin
            state      <= stop;
            halted     <= 1'b1;
            halt_cause <= core_pkg::halt_ebreak;
          end else if (invalid_inst) begin
            state      <= stop;
            halted     <= 1'b1;
            halt_cause <= core_pkg::halt_illegal;
          end else begin
            // next request goes out right after commit
            pc      <= next_pc;
            arvalid <= 1'b1;
            state   <= fetch_addr;
          end
        end
        default: begin
          // parked until reset
          state <= stop;
        end
      endcase
    end
  end

  // latched word, held for the execute cycle
  always_ff @(posedge clk) begin
    if (state == fetch_data && rvalid && rresp == 2'b00) begin
      inst <= rdata;
    end
  end

endmodule

// ==== rtl/idu.sv ====
module idu (
  input  logic [31:0]                pc,
  input  logic [31:0]                inst,
  input  logic [core_pkg::xlen-1:0]  rs1_data,
  output core_pkg::alu_op_e          alu_op,
  output logic [core_pkg::xlen-1:0]  op1,
  output logic [core_pkg::xlen-1:0]  op2,
  output logic [31:0]                op1_jump,
  output logic [31:0]                op2_jump,
  output logic                       jump_flag,
  output logic                       inst_ebreak,
  output logic                       invalid_inst,
  output logic                       rs1_r_en,
  output logic [4:0]                 rs1_r_addr,
  output logic                       rd_w_en,
  output logic [4:0]                 rd_w_addr
);

  rv_isa_pkg::rv_opcode_e     opcode;
  rv_isa_pkg::imm_fmt_e       imm_fmt;
  logic [2:0]                 funct3;
  logic [4:0]                 rd;
  logic [4:0]                 rs1;
  logic [core_pkg::xlen-1:0]  imm;
  logic [core_pkg::xlen-1:0]  pc_ext;
  logic                       inst_addi;
  logic                       inst_auipc;
  logic                       inst_lui;
  logic                       inst_jal;
  logic                       inst_jalr;

  // instruction fields
  assign opcode = rv_isa_pkg::rv_opcode_e'(inst[6:0]);
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];

  // pc is a 32-bit address, zero-extended as an operand
  assign pc_ext = {{(core_pkg::xlen - 32){1'b0}}, pc};

  // class flags
  assign inst_addi  = (opcode == rv_isa_pkg::op_imm) && (funct3 == rv_isa_pkg::funct3_addi);
  assign inst_auipc = (opcode == rv_isa_pkg::auipc);
  assign inst_lui   = (opcode == rv_isa_pkg::lui);
  assign inst_jal   = (opcode == rv_isa_pkg::jal);
  assign inst_jalr  = (opcode == rv_isa_pkg::jalr);
  assign inst_ebreak = (opcode == rv_isa_pkg::system) &&
                       (funct3 == rv_isa_pkg::funct3_priv) &&
                       (inst[31:20] == rv_isa_pkg::imm_ebreak);

  // anything else halts, the all-zero word included
  assign invalid_inst = !(inst_addi || inst_auipc || inst_lui ||
                          inst_jal || inst_jalr || inst_ebreak);

  assign jump_flag = inst_jal || inst_jalr;

  // immediate layout per major opcode
  always_comb begin
    case (opcode)
      rv_isa_pkg::op_imm,
      rv_isa_pkg::jalr,
      rv_isa_pkg::system: imm_fmt = rv_isa_pkg::fmt_i;
      rv_isa_pkg::auipc,
      rv_isa_pkg::lui:    imm_fmt = rv_isa_pkg::fmt_u;
      rv_isa_pkg::jal:    imm_fmt = rv_isa_pkg::fmt_j;
      default:            imm_fmt = rv_isa_pkg::fmt_none;
    endcase
  end

  // sign extension to xlen
  always_comb begin
    case (imm_fmt)
      rv_isa_pkg::fmt_i: imm = {{(core_pkg::xlen - 12){inst[31]}}, inst[31:20]};
      rv_isa_pkg::fmt_u: imm = {{(core_pkg::xlen - 32){inst[31]}}, inst[31:12], 12'b0};
      // j offset is scattered, bit 0 always zero
      rv_isa_pkg::fmt_j: imm = {{(core_pkg::xlen - 21){inst[31]}}, inst[31], inst[19:12],
                                inst[20], inst[30:21], 1'b0};
      default:           imm = '0;
    endcase
  end

  // operands and register-file enables
  always_comb begin
    alu_op     = core_pkg::alu_none;
    op1        = '0;
    op2        = '0;
    op1_jump   = '0;
    op2_jump   = '0;
    rs1_r_en   = 1'b0;
    rs1_r_addr = '0;
    rd_w_en    = 1'b0;
    rd_w_addr  = '0;
    if (inst_addi) begin
      alu_op     = core_pkg::alu_add;
      rs1_r_en   = 1'b1;
      rs1_r_addr = rs1;
      rd_w_en    = 1'b1;
      rd_w_addr  = rd;
      op1        = rs1_data;
      op2        = imm;
    end else if (inst_auipc || inst_lui) begin
      // lui adds to zero
      alu_op    = core_pkg::alu_add;
      rd_w_en   = 1'b1;
      rd_w_addr = rd;
      op1       = inst_auipc ? pc_ext : '0;
      op2       = imm;
    end else if (inst_jal || inst_jalr) begin
      // link value is pc + 4, target goes through the jump operands
      alu_op    = core_pkg::alu_add;
      rd_w_en   = 1'b1;
      rd_w_addr = rd;
      op1       = pc_ext;
      op2       = 64'd4;
      op2_jump  = imm[31:0];
      if (inst_jalr) begin
        rs1_r_en   = 1'b1;
        rs1_r_addr = rs1;
        op1_jump   = rs1_data[31:0];
      end else begin
        op1_jump = pc;
      end
    end
  end

endmodule

// ==== rtl/exu.sv ====
module exu (
  input  logic [31:0]                pc,
  input  core_pkg::alu_op_e          alu_op,
  input  logic [core_pkg::xlen-1:0]  op1,
  input  logic [core_pkg::xlen-1:0]  op2,
  input  logic [31:0]                op1_jump,
  input  logic [31:0]                op2_jump,
  input  logic                       jump_flag,
  output logic [core_pkg::xlen-1:0]  rd_data,
  output logic [31:0]                next_pc
);

  logic [31:0] jump_sum;
  logic [31:0] seq_pc;

  // result adder, idle ops give zero
  always_comb begin
    case (alu_op)
      core_pkg::alu_add: rd_data = op1 + op2;
      default:           rd_data = '0;
    endcase
  end

  // jump target adder
  assign jump_sum = op1_jump + op2_jump;

  // fall-through address
  assign seq_pc = pc + 32'd4;

  // target lsb cleared, matters for jalr with an odd sum
  assign next_pc = jump_flag ? {jump_sum[31:1], 1'b0} : seq_pc;

endmodule

// ==== rtl/regfile.sv ====
module regfile (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       rs1_r_en,
  input  logic [4:0]                 rs1_r_addr,
  input  logic                       rd_w_en,
  input  logic [4:0]                 rd_w_addr,
  input  logic [core_pkg::xlen-1:0]  rd_data,
  input  logic                       exec_valid,
  output logic [core_pkg::xlen-1:0]  rs1_data
);

  logic [core_pkg::xlen-1:0] regs [32];

  // write only in the execute cycle, x0 never stored
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (exec_valid && rd_w_en && (rd_w_addr != 5'd0)) begin
      regs[rd_w_addr] <= rd_data;
    end
  end

  // async read
  // x0 and disabled reads give zero
  assign rs1_data = (rs1_r_en && (rs1_r_addr != 5'd0)) ? regs[rs1_r_addr] : '0;

endmodule

// ==== rtl/core_top.sv ====
module core_top #(
  parameter logic [31:0] reset_pc = 32'h8000_0000
) (
  input  logic                       clk,
  input  logic                       reset,
  // instruction fetch, axi4-lite read only
  output logic [31:0]                araddr,
  output logic [2:0]                 arprot,
  output logic                       arvalid,
  input  logic                       arready,
  input  logic [31:0]                rdata,
  input  logic [1:0]                 rresp,
  input  logic                       rvalid,
  output logic                       rready,
  // retire trace
  output logic                       commit_valid,
  output logic [31:0]                commit_pc,
  output logic [31:0]                commit_inst,
  output logic                       commit_rd_en,
  output logic [4:0]                 commit_rd,
  output logic [core_pkg::xlen-1:0]  commit_data,
  output logic                       commit_jump,
  // status
  output logic                       halted,
  output core_pkg::halt_cause_e      halt_cause
);

  logic [31:0]                inst;
  logic [31:0]                pc;
  logic [31:0]                next_pc;
  logic                       exec_valid;
  logic                       inst_ebreak;
  logic                       invalid_inst;
  core_pkg::alu_op_e          alu_op;
  logic [core_pkg::xlen-1:0]  op1;
  logic [core_pkg::xlen-1:0]  op2;
  logic [31:0]                op1_jump;
  logic [31:0]                op2_jump;
  logic                       jump_flag;
  logic                       rs1_r_en;
  logic [4:0]                 rs1_r_addr;
  logic [core_pkg::xlen-1:0]  rs1_data;
  logic                       rd_w_en;
  logic [4:0]                 rd_w_addr;
  logic [core_pkg::xlen-1:0]  rd_data;

  ifu #(
    .reset_pc(reset_pc)
  ) ifu0 (
    .clk          (clk),
    .reset        (reset),
    .araddr       (araddr),
    .arprot       (arprot),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .inst_ebreak  (inst_ebreak),
    .invalid_inst (invalid_inst),
    .next_pc      (next_pc),
    .inst         (inst),
    .pc           (pc),
    .exec_valid   (exec_valid),
    .halted       (halted),
    .halt_cause   (halt_cause)
  );

  idu idu0 (
    .pc           (pc),
    .inst         (inst),
    .rs1_data     (rs1_data),
    .alu_op       (alu_op),
    .op1          (op1),
    .op2          (op2),
    .op1_jump     (op1_jump),
    .op2_jump     (op2_jump),
    .jump_flag    (jump_flag),
    .inst_ebreak  (inst_ebreak),
    .invalid_inst (invalid_inst),
    .rs1_r_en     (rs1_r_en),
    .rs1_r_addr   (rs1_r_addr),
    .rd_w_en      (rd_w_en),
    .rd_w_addr    (rd_w_addr)
  );

  exu exu0 (
    .pc        (pc),
    .alu_op    (alu_op),
    .op1       (op1),
    .op2       (op2),
    .op1_jump  (op1_jump),
    .op2_jump  (op2_jump),
    .jump_flag (jump_flag),
    .rd_data   (rd_data),
    .next_pc   (next_pc)
  );

  regfile regfile0 (
    .clk        (clk),
    .reset      (reset),
    .rs1_r_en   (rs1_r_en),
    .rs1_r_addr (rs1_r_addr),
    .rd_w_en    (rd_w_en),
    .rd_w_addr  (rd_w_addr),
    .rd_data    (rd_data),
    .exec_valid (exec_valid),
    .rs1_data   (rs1_data)
  );

  // commit port is the execute-cycle view
  assign commit_valid = exec_valid;
  assign commit_pc    = pc;
  assign commit_inst  = inst;
  assign commit_rd_en = rd_w_en;
  assign commit_rd    = rd_w_addr;
  assign commit_data  = rd_data;
  assign commit_jump  = jump_flag;

endmodule

// ==== testbench/tb_core.sv ====
module tb_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] tb_reset_pc = 32'h8000_0000;

  logic                   clk;
  logic                   reset;
  logic [31:0]            araddr;
  logic [2:0]             arprot;
  logic                   arvalid;
  logic                   arready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;
  logic                   commit_valid;
  logic [31:0]            commit_pc;
  logic [31:0]            commit_inst;
  logic                   commit_rd_en;
  logic [4:0]             commit_rd;
  logic [63:0]            commit_data;
  logic                   commit_jump;
  logic                   halted;
  core_pkg::halt_cause_e  halt_cause;

  // instruction memory, one word per 4 bytes from reset_pc
  logic [31:0]  mem [64];
  logic         err_flag [64];
  // wait-state generator
  logic [15:0]  lfsr;
  logic         random_waits;
  logic [1:0]   ar_wait;
  logic [1:0]   r_wait;
  logic         r_pending;
  logic [31:0]  r_addr;
  // reference model state
  logic [63:0]  ref_regs [32];
  logic [31:0]  ref_pc;
  int           commit_count;
  logic         ar_stalled;
  logic [31:0]  ar_stalled_addr;
  int           error_count;
  int           pass_count;
  int           fail_count;

  core_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .araddr       (araddr),
    .arprot       (arprot),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_rd_en (commit_rd_en),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .commit_jump  (commit_jump),
    .halted       (halted),
    .halt_cause   (halt_cause)
  );

  always #10 clk = ~clk;

  // galois lfsr, one step per bit
  function automatic logic rand_bit();
    logic out;
    out = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]};
    if (out) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return out;
  endfunction

  // two bits per wait count, zero when waits are off
  function automatic logic [1:0] wait_count();
    logic hi;
    logic lo;
    if (!random_waits) begin
      return 2'd0;
    end
    hi = rand_bit();
    lo = rand_bit();
    return {hi, lo};
  endfunction

  // out of range reads give the all-zero word
  function automatic logic [31:0] word_at(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - tb_reset_pc;
    if (offset[31:8] != 24'd0) begin
      return 32'd0;
    end
    return mem[offset[7:2]];
  endfunction

  function automatic logic error_at(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - tb_reset_pc;
    if (offset[31:8] != 24'd0) begin
      return 1'b0;
    end
    return err_flag[offset[7:2]];
  endfunction

  function automatic logic [31:0] encode_itype(rv_isa_pkg::rv_opcode_e opc, logic [4:0] rd,
                                               logic [2:0] f3, logic [4:0] rs1,
                                               logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_utype(rv_isa_pkg::rv_opcode_e opc, logic [4:0] rd,
                                               logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // j offset bits are scattered over the word
  function automatic logic [31:0] encode_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::jal};
  endfunction

  function automatic logic [31:0] encode_addi(logic [4:0] rd, logic [4:0] rs1,
                                              logic [11:0] imm);
    return encode_itype(rv_isa_pkg::op_imm, rd, rv_isa_pkg::funct3_addi, rs1, imm);
  endfunction

  function automatic logic [31:0] encode_ebreak();
    return encode_itype(rv_isa_pkg::system, 5'd0, rv_isa_pkg::funct3_priv, 5'd0,
                        rv_isa_pkg::imm_ebreak);
  endfunction

  task automatic compare_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR at %0d ns: %s expected %h got %h", $time, what, expected, actual);
      error_count++;
    end
  endtask

  // axi4-lite read slave
  always @(posedge clk) begin
    if (reset) begin
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      rdata     <= '0;
      rresp     <= 2'b00;
      r_pending <= 1'b0;
      r_wait    <= 2'd0;
      r_addr    <= '0;
      ar_wait   <= wait_count();
    end else begin
      // address channel
      if (arvalid && arready) begin
        arready   <= 1'b0;
        r_addr    <= araddr;
        r_pending <= 1'b1;
        r_wait    <= wait_count();
        ar_wait   <= wait_count();
      end else if (arvalid) begin
        if (ar_wait == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_wait <= ar_wait - 2'd1;
        end
      end
      // data channel, slverr on flagged words
      if (rvalid && rready) begin
        rvalid    <= 1'b0;
        r_pending <= 1'b0;
      end else if (r_pending && !rvalid) begin
        if (r_wait == 2'd0) begin
          rvalid <= 1'b1;
          rdata  <= word_at(r_addr);
          rresp  <= error_at(r_addr) ? 2'b10 : 2'b00;
        end else begin
          r_wait <= r_wait - 2'd1;
        end
      end
    end
  end

  // reference commit, decoded from the memory word at the expected pc
  task automatic verify_commit();
    logic [31:0] word;
    logic [4:0]  rd;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] rs1_val;
    logic [63:0] pc_ext;
    logic [63:0] exp_data;
    logic [31:0] exp_next;
    logic [31:0] target;
    logic        exp_en;
    logic        exp_jump;
    word     = word_at(ref_pc);
    rd       = word[11:7];
    imm_i    = {{52{word[31]}}, word[31:20]};
    imm_u    = {{32{word[31]}}, word[31:12], 12'h000};
    imm_j    = {{44{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    rs1_val  = ref_regs[word[19:15]];
    pc_ext   = {32'h0, ref_pc};
    exp_en   = 1'b1;
    exp_jump = 1'b0;
    exp_data = '0;
    exp_next = ref_pc + 32'd4;
    case (word[6:0])
      rv_isa_pkg::op_imm: begin
        exp_en   = (word[14:12] == rv_isa_pkg::funct3_addi);
        exp_data = rs1_val + imm_i;
      end
      rv_isa_pkg::lui:   exp_data = imm_u;
      rv_isa_pkg::auipc: exp_data = pc_ext + imm_u;
      rv_isa_pkg::jal: begin
        exp_data = pc_ext + 64'd4;
        exp_jump = 1'b1;
        exp_next = ref_pc + imm_j[31:0];
      end
      rv_isa_pkg::jalr: begin
        exp_data = pc_ext + 64'd4;
        exp_jump = 1'b1;
        target   = rs1_val[31:0] + imm_i[31:0];
        exp_next = {target[31:1], 1'b0};
      end
      // ebreak and illegal words retire without a write
      default: exp_en = 1'b0;
    endcase
    compare_value("commit_pc", 64'(ref_pc), 64'(commit_pc));
    compare_value("commit_inst", 64'(word), 64'(commit_inst));
    compare_value("commit_rd_en", 64'(exp_en), 64'(commit_rd_en));
    compare_value("commit_jump", 64'(exp_jump), 64'(commit_jump));
    if (exp_en) begin
      compare_value("commit_rd", 64'(rd), 64'(commit_rd));
      compare_value("commit_data", exp_data, commit_data);
      if (rd != 5'd0) begin
        ref_regs[rd] = exp_data;
      end
    end
    ref_pc = exp_next;
    commit_count++;
  endtask

  // commit and read-address monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      ar_stalled = 1'b0;
    end else begin
      // a stalled request keeps valid and address
      if (ar_stalled) begin
        compare_value("arvalid held", 64'(1'b1), 64'(arvalid));
        compare_value("araddr held", 64'(ar_stalled_addr), 64'(araddr));
      end
      if (arvalid) begin
        compare_value("arprot", 64'(3'b000), 64'(arprot));
      end
      ar_stalled      = arvalid && !arready;
      ar_stalled_addr = araddr;
      if (commit_valid) begin
        verify_commit();
      end
    end
  end

  task automatic clear_mem();
    int i;
    for (i = 0; i < 64; i++) begin
      mem[i]      = 32'd0;
      err_flag[i] = 1'b0;
    end
  endtask

  // reset, run until halted, then watch the bus stay quiet
  task automatic run_program(input string name, input int exp_commits,
                             input core_pkg::halt_cause_e exp_cause);
    int i;
    int cycles;
    @(posedge clk);
    reset <= 1'b1;
    ref_pc       = tb_reset_pc;
    commit_count = 0;
    for (i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    compare_value("arvalid in reset", 64'(1'b0), 64'(arvalid));
    compare_value("rready in reset", 64'(1'b0), 64'(rready));
    compare_value("commit_valid in reset", 64'(1'b0), 64'(commit_valid));
    compare_value("halted in reset", 64'(1'b0), 64'(halted));
    compare_value("halt_cause in reset", 64'(core_pkg::halt_none), 64'(halt_cause));
    @(posedge clk);
    reset <= 1'b0;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout: program %s did not halt within 2000 cycles", name);
      error_count++;
    end else begin
      compare_value("halt_cause", 64'(exp_cause), 64'(halt_cause));
      for (i = 0; i < 20; i++) begin
        @(negedge clk);
        compare_value("arvalid after halt", 64'(1'b0), 64'(arvalid));
      end
      compare_value("commit count", 64'(exp_commits), 64'(commit_count));
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("%-12s passed", name);
      pass_count++;
    end else begin
      $display("%-12s failed with %0d errors", name, error_count - errors_before);
      fail_count++;
    end
  endtask

  task automatic load_upper();
    clear_mem();
    mem[0] = encode_utype(rv_isa_pkg::lui, 5'd1, 20'h12345);
    // bit 31 set, upper 32 bits become ones
    mem[1] = encode_utype(rv_isa_pkg::lui, 5'd2, 20'h80000);
    mem[2] = encode_utype(rv_isa_pkg::auipc, 5'd3, 20'hfffff);
    mem[3] = encode_utype(rv_isa_pkg::auipc, 5'd4, 20'h00010);
    mem[4] = encode_ebreak();
  endtask

  task automatic load_addi();
    clear_mem();
    mem[0] = encode_addi(5'd1, 5'd0, 12'(-5));
    mem[1] = encode_addi(5'd2, 5'd1, 12'd100);
    mem[2] = encode_addi(5'd2, 5'd2, 12'h800);
    // x0 write retires, x0 still reads zero after
    mem[3] = encode_addi(5'd0, 5'd1, 12'd7);
    mem[4] = encode_addi(5'd3, 5'd0, 12'd1);
    mem[5] = encode_addi(5'd4, 5'd2, 12'd0);
    mem[6] = encode_ebreak();
  endtask

  task automatic load_jal();
    clear_mem();
    // 0 -> 4 forward, 4 -> 2 backward, word 1 never reached
    mem[0] = encode_jal(5'd1, 21'd16);
    mem[2] = encode_addi(5'd5, 5'd0, 12'd3);
    mem[3] = encode_ebreak();
    mem[4] = encode_jal(5'd2, 21'(-8));
  endtask

  task automatic load_jalr();
    clear_mem();
    mem[0] = encode_utype(rv_isa_pkg::lui, 5'd1, 20'h80000);
    // odd sums, lsb dropped from the target
    mem[1] = encode_itype(rv_isa_pkg::jalr, 5'd2, 3'd0, 5'd1, 12'd21);
    mem[5] = encode_addi(5'd3, 5'd2, 12'd1);
    mem[6] = encode_itype(rv_isa_pkg::jalr, 5'd0, 3'd0, 5'd1, 12'd29);
    mem[7] = encode_ebreak();
  endtask

  task automatic upper_imm_test();
    int errors_before;
    errors_before = error_count;
    load_upper();
    run_program("upper", 5, core_pkg::halt_ebreak);
    report_test("lui_auipc", errors_before);
  endtask

  task automatic addi_chain_test();
    int errors_before;
    errors_before = error_count;
    load_addi();
    run_program("addi", 7, core_pkg::halt_ebreak);
    report_test("addi_chain", errors_before);
  endtask

  task automatic jal_test();
    int errors_before;
    errors_before = error_count;
    load_jal();
    run_program("jal", 4, core_pkg::halt_ebreak);
    report_test("jal", errors_before);
  endtask

  task automatic jalr_test();
    int errors_before;
    errors_before = error_count;
    load_jalr();
    run_program("jalr", 5, core_pkg::halt_ebreak);
    report_test("jalr", errors_before);
  endtask

  task automatic halt_test();
    int errors_before;
    errors_before = error_count;
    clear_mem();
    mem[0] = encode_addi(5'd1, 5'd0, 12'd1);
    run_program("zero word", 2, core_pkg::halt_illegal);
    clear_mem();
    // r-type add, not decoded here
    mem[0] = 32'h0000_0033;
    run_program("unsupported", 1, core_pkg::halt_illegal);
    clear_mem();
    mem[0] = encode_addi(5'd1, 5'd0, 12'd1);
    mem[1] = encode_addi(5'd2, 5'd0, 12'd2);
    err_flag[1] = 1'b1;
    run_program("fetch error", 1, core_pkg::halt_fetch_err);
    report_test("halts", errors_before);
  endtask

  task automatic wait_state_test();
    int errors_before;
    errors_before = error_count;
    random_waits = 1'b1;
    load_upper();
    run_program("upper waits", 5, core_pkg::halt_ebreak);
    load_addi();
    run_program("addi waits", 7, core_pkg::halt_ebreak);
    load_jal();
    run_program("jal waits", 4, core_pkg::halt_ebreak);
    load_jalr();
    run_program("jalr waits", 5, core_pkg::halt_ebreak);
    random_waits = 1'b0;
    report_test("wait_states", errors_before);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    arready      = 1'b0;
    rdata        = '0;
    rresp        = 2'b00;
    rvalid       = 1'b0;
    lfsr         = 16'd66;
    random_waits = 1'b0;
    error_count  = 0;
    pass_count   = 0;
    fail_count   = 0;
    clear_mem();
    upper_imm_test();
    addi_chain_test();
    jal_test();
    jalr_test();
    halt_test();
    wait_state_test();
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/regfile.sv
rtl/core_top.sv
testbench/tb_core.sv

// ==== Makefile ====
# Verilator build for the RV64 core and its testbench

VERILATOR ?= verilator
TOP       ?= tb_core
LOG       ?= sim.log
FLAGS     ?=

OBJ_DIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f build.f --top-module core_top $(FLAGS)

sim:
	$(VERILATOR) --binary --timing -f build.f --top-module $(TOP) --Mdir $(OBJ_DIR) $(FLAGS)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
